//--- jesd_up_params.svh
// **************************************************************************
// JESD204 processor-side control. Widths, counts and timing constants
// shared by the package and the RTL.
// **************************************************************************

`ifndef JESD_UP_PARAMS_SVH
`define JESD_UP_PARAMS_SVH

// register bus.
`define JESD_UP_ADDR_W 12
`define JESD_UP_DATA_W 32

// link shape.
`define JESD_UP_NUM_LANES 4
`define JESD_UP_NUM_IRQS 2
`define JESD_UP_DPW_LOG2 2 // bytes per beat, log2.

// clock monitor, window counted in up_clk cycles.
`define JESD_UP_CLKMON_WINDOW 256
`define JESD_UP_CLKMON_W 21

// domain reset release length, in domain clocks.
`define JESD_UP_RESET_LEN 5

`define JESD_UP_VERSION 32'h0001_0361

`endif

//--- jesd_up_pkg.sv
// **************************************************************************
// JESD204 processor-side control types. Bus words, counters and link
// configuration.
// **************************************************************************

`include "jesd_up_params.svh"

package jesd_up_pkg;

  typedef logic [`JESD_UP_ADDR_W-1:0] addr_t; // word address.
  typedef logic [`JESD_UP_DATA_W-1:0] data_t;
  typedef logic [`JESD_UP_NUM_LANES-1:0] lanes_t;
  typedef logic [`JESD_UP_NUM_IRQS-1:0] irq_vec_t;
  typedef logic [`JESD_UP_CLKMON_W-1:0] clk_count_t;
  typedef logic [15:0] stat_cnt_t;

  // request from the bus master.
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // response, held until taken.
  typedef struct packed {
    data_t rdata;
    logic  is_write; // set when answering a write.
  } bus_rsp_t;

  typedef struct packed {
    lanes_t     lanes_disable;
    logic [9:0] octets_per_multiframe;
    logic [7:0] octets_per_frame;
    logic [7:0] beats_per_multiframe;
    logic       disable_scrambler;
    logic       disable_char_replacement;
    logic [1:0] header_mode; // crc12, crc3, fec, cmd.
  } link_cfg_t;

endpackage

//--- jesd_up_bus_bridge.sv
// **************************************************************************
// Register bus bridge. Valid/ready requests in, single-cycle register
// strobes out, one held response per request.
// **************************************************************************

`timescale 1ns/1ps

module jesd_up_bus_bridge (
  input  logic                  up_clk,
  input  logic                  core_reset_all,
  input  jesd_up_pkg::bus_req_t req,
  input  logic                  req_valid,
  output logic                  req_ready,
  output jesd_up_pkg::bus_rsp_t rsp,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output logic                  wreq,
  output jesd_up_pkg::addr_t    waddr,
  output jesd_up_pkg::addr_t    raddr,
  output jesd_up_pkg::data_t    wdata,
  input  jesd_up_pkg::data_t    rdata
);

  logic accept;

  // one transaction in flight, so a held response blocks new requests.
  assign req_ready = ~rsp_valid;
  assign accept = req_valid & req_ready;

  // strobes are valid only in the accept cycle.
  assign wreq = accept & req.write;
  assign waddr = req.addr;
  assign raddr = req.addr;
  assign wdata = req.wdata;

  always_ff @(posedge up_clk or posedge core_reset_all) begin
    if (core_reset_all) begin
      rsp_valid <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0; // taken.
    end
  end

  // read data is sampled in the accept cycle, while raddr still points at it.
  always_ff @(posedge up_clk) begin
    if (accept) begin
      rsp.rdata <= req.write ? '0 : rdata;
      rsp.is_write <= req.write;
    end
  end

endmodule

//--- jesd_up_clock_mon.sv
// **************************************************************************
// Clock monitor. Counts domain clock edges over a fixed up_clk window and
// returns the result in the up_clk domain.
// **************************************************************************

`timescale 1ns/1ps

`include "jesd_up_params.svh"

module jesd_up_clock_mon (
  input  logic                    up_clk,
  input  logic                    core_reset_all,
  input  logic                    d_clk,
  output jesd_up_pkg::clk_count_t count
);

  localparam int WIN_W = $clog2(`JESD_UP_CLKMON_WINDOW);

  logic [WIN_W-1:0]        win_cnt;
  logic                    up_req;
  logic [2:0]              up_ack_sync;
  logic [2:0]              d_req_sync;
  logic                    d_toggle;
  logic                    d_ack;
  jesd_up_pkg::clk_count_t d_count;
  jesd_up_pkg::clk_count_t d_snap;

  // **************************************************************************
  // up_clk side
  // **************************************************************************

  always_ff @(posedge up_clk or posedge core_reset_all) begin
    if (core_reset_all) begin
      win_cnt <= '0;
      up_req <= 1'b0;
    end else if (win_cnt == WIN_W'(`JESD_UP_CLKMON_WINDOW - 1)) begin
      win_cnt <= '0;
      up_req <= ~up_req; // end of window.
    end else begin
      win_cnt <= win_cnt + 1'b1;
    end
  end

  // the snapshot is stable for many cycles before the ack edge shows up.
  always_ff @(posedge up_clk or posedge core_reset_all) begin
    if (core_reset_all) begin
      up_ack_sync <= '0;
      count <= '0;
    end else begin
      up_ack_sync <= {up_ack_sync[1:0], d_ack};
      if (up_ack_sync[2] ^ up_ack_sync[1]) begin
        count <= d_snap;
      end
    end
  end

  // **************************************************************************
  // domain side
  // **************************************************************************

  assign d_toggle = d_req_sync[2] ^ d_req_sync[1];

  always_ff @(posedge d_clk or posedge core_reset_all) begin
    if (core_reset_all) begin
      d_req_sync <= '0;
      d_count <= '0;
      d_ack <= 1'b0;
    end else begin
      d_req_sync <= {d_req_sync[1:0], up_req};
      if (d_toggle) begin
        d_count <= jesd_up_pkg::clk_count_t'(1); // this edge starts the next window.
        d_ack <= ~d_ack;
      end else if (~&d_count) begin
        d_count <= d_count + 1'b1; // saturates on a runaway clock.
      end
    end
  end

  always_ff @(posedge d_clk) begin
    if (d_toggle) begin
      d_snap <= d_count;
    end
  end

endmodule

//--- jesd_up_domain_ctrl.sv
// **************************************************************************
// Domain controller. Reset release chain, configuration capture, ready
// flag and clock monitor for one link clock domain.
// **************************************************************************

`timescale 1ns/1ps

`include "jesd_up_params.svh"

module jesd_up_domain_ctrl (
  input  logic                    up_clk,
  input  logic                    core_reset_all,
  input  logic                    d_clk,
  input  logic                    link_reset,
  input  logic                    ext_reset,
  input  jesd_up_pkg::link_cfg_t  cfg,
  output logic                    d_reset,
  output jesd_up_pkg::link_cfg_t  d_cfg,
  output logic                    ready,
  output jesd_up_pkg::clk_count_t clk_count
);

  logic                           reset_any;
  logic [`JESD_UP_RESET_LEN-1:0]  reset_chain;
  logic                           cfg_load;
  logic [1:0]                     ready_sync;

  assign reset_any = link_reset | ext_reset;
  assign d_reset = reset_chain[0];

  // asserts at once, releases after the chain has drained.
  always_ff @(posedge d_clk or posedge reset_any) begin
    if (reset_any) begin
      reset_chain <= '1;
    end else begin
      reset_chain <= {1'b0, reset_chain[`JESD_UP_RESET_LEN-1:1]};
    end
  end

  // cfg is frozen by the regmap while link_reset is low, so it is safe to
  // sample here with no synchronizer.
  assign cfg_load = reset_chain[2] ^ reset_chain[1];

  always_ff @(posedge d_clk) begin
    if (cfg_load) begin
      d_cfg <= cfg;
    end
  end

  always_ff @(posedge up_clk or posedge d_reset) begin
    if (d_reset) begin
      ready_sync <= 2'b00;
    end else begin
      ready_sync <= {ready_sync[0], 1'b1};
    end
  end

  assign ready = ready_sync[1];

  jesd_up_clock_mon clock_mon_i (
    .up_clk         (up_clk),
    .core_reset_all (core_reset_all),
    .d_clk          (d_clk),
    .count          (clk_count)
  );

endmodule

//--- jesd_up_regmap.sv
// **************************************************************************
// Register map. Identity, interrupts, link reset, link configuration with
// write lock, statistics and link status.
// **************************************************************************

`timescale 1ns/1ps

`include "jesd_up_params.svh"

module jesd_up_regmap (
  input  logic                    up_clk,
  input  logic                    core_reset_all,
  input  logic                    wreq,
  input  jesd_up_pkg::addr_t      waddr,
  input  jesd_up_pkg::addr_t      raddr,
  input  jesd_up_pkg::data_t      wdata,
  output jesd_up_pkg::data_t      rdata,
  input  jesd_up_pkg::irq_vec_t   irq_trigger,
  output logic                    irq,
  output logic                    link_reset,
  output jesd_up_pkg::link_cfg_t  cfg,
  input  logic                    core_ready,
  input  logic                    device_ready,
  input  jesd_up_pkg::clk_count_t core_count,
  input  jesd_up_pkg::clk_count_t device_count
);

  localparam int DPW = `JESD_UP_DPW_LOG2;

  jesd_up_pkg::data_t                                 scratch;
  jesd_up_pkg::irq_vec_t                              irq_enable;
  jesd_up_pkg::irq_vec_t                              irq_source;
  jesd_up_pkg::irq_vec_t                              irq_pending;
  jesd_up_pkg::irq_vec_t                              irq_clear;
  logic                                               link_reset_d;
  logic                                               stat_clear;
  jesd_up_pkg::stat_cnt_t                             link_enable_cnt;
  jesd_up_pkg::stat_cnt_t [`JESD_UP_NUM_IRQS-1:0]     irq_event_cnt;

  // **************************************************************************
  // control and configuration writes
  // **************************************************************************

  always_ff @(posedge up_clk or posedge core_reset_all) begin
    if (core_reset_all) begin
      scratch <= '0;
      irq_enable <= '0;
      link_reset <= 1'b1;
      cfg <= '0;
      cfg.octets_per_multiframe <= 10'({DPW{1'b1}});
    end else if (wreq) begin
      case (waddr)
        12'h002: scratch <= wdata;
        12'h020: irq_enable <= jesd_up_pkg::irq_vec_t'(wdata);
        12'h030: link_reset <= wdata[0];
        default: ;
      endcase

      // configuration is locked while the link runs.
      if (link_reset) begin
        case (waddr)
          12'h080: cfg.lanes_disable <= jesd_up_pkg::lanes_t'(wdata);
          12'h084: begin
            cfg.octets_per_frame <= wdata[23:16];
            cfg.octets_per_multiframe <= {wdata[9:DPW], {DPW{1'b1}}}; // whole beats.
          end
          12'h085: begin
            cfg.header_mode <= wdata[3:2];
            cfg.disable_char_replacement <= wdata[1];
            cfg.disable_scrambler <= wdata[0];
          end
          12'h087: cfg.beats_per_multiframe <= wdata[7:0];
          default: ;
        endcase
      end
    end
  end

  // **************************************************************************
  // interrupts
  // **************************************************************************

  assign irq_clear = (wreq && waddr == 12'h021) ? jesd_up_pkg::irq_vec_t'(wdata) : '0;
  assign irq_pending = irq_source & irq_enable;

  always_ff @(posedge up_clk or posedge core_reset_all) begin
    if (core_reset_all) begin
      irq_source <= '0;
      irq <= 1'b0;
    end else begin
      irq_source <= (irq_source & ~irq_clear) | irq_trigger; // a new trigger wins.
      irq <= |irq_pending;
    end
  end

  // **************************************************************************
  // statistics
  // **************************************************************************

  assign stat_clear = wreq && waddr == 12'h0b0 && wdata[0];

  always_ff @(posedge up_clk or posedge core_reset_all) begin
    if (core_reset_all) begin
      link_reset_d <= 1'b1;
      link_enable_cnt <= '0;
      irq_event_cnt <= '0;
    end else begin
      link_reset_d <= link_reset;
      if (stat_clear) begin
        link_enable_cnt <= '0;
        irq_event_cnt <= '0;
      end else begin
        if (link_reset_d && !link_reset) begin
          link_enable_cnt <= link_enable_cnt + 1'b1; // link enabled.
        end
        for (int i = 0; i < `JESD_UP_NUM_IRQS; i++) begin
          if (irq_trigger[i]) begin
            irq_event_cnt[i] <= irq_event_cnt[i] + 1'b1;
          end
        end
      end
    end
  end

  // **************************************************************************
  // read mux
  // **************************************************************************

  always_comb begin
    case (raddr)
      12'h000: rdata = `JESD_UP_VERSION;
      12'h002: rdata = scratch;
      12'h020: rdata = jesd_up_pkg::data_t'(irq_enable);
      12'h021: rdata = jesd_up_pkg::data_t'(irq_pending);
      12'h022: rdata = jesd_up_pkg::data_t'(irq_source);
      12'h030: rdata = jesd_up_pkg::data_t'(link_reset);
      12'h031: rdata = {30'd0, device_ready, core_ready};
      12'h032: rdata = jesd_up_pkg::data_t'(core_count); // domain edges per window.
      12'h033: rdata = jesd_up_pkg::data_t'(device_count);
      12'h080: rdata = jesd_up_pkg::data_t'(cfg.lanes_disable);
      12'h084: rdata = {8'd0, cfg.octets_per_frame, 6'd0, cfg.octets_per_multiframe};
      12'h085: begin
        rdata = {28'd0, cfg.header_mode, cfg.disable_char_replacement,
                 cfg.disable_scrambler};
      end
      12'h087: rdata = jesd_up_pkg::data_t'(cfg.beats_per_multiframe);
      12'h0b1: rdata = jesd_up_pkg::data_t'(link_enable_cnt);
      12'h0b4: rdata = jesd_up_pkg::data_t'(irq_event_cnt); // irq 0 in the low half.
      default: rdata = '0;
    endcase
  end

endmodule

//--- jesd_up_top.sv
// **************************************************************************
// JESD204 processor-side control top. Bus bridge, register map and the
// core and device domain controllers.
// **************************************************************************

`timescale 1ns/1ps

module jesd_up_top (
  input  logic                   up_clk,
  input  logic                   core_reset_all,
  input  logic                   core_clk,
  input  logic                   device_clk,
  input  logic                   core_reset_ext,
  input  jesd_up_pkg::bus_req_t  req,
  input  logic                   req_valid,
  output logic                   req_ready,
  output jesd_up_pkg::bus_rsp_t  rsp,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  input  jesd_up_pkg::irq_vec_t  irq_trigger,
  output logic                   irq,
  output logic                   core_reset,
  output logic                   device_reset,
  output jesd_up_pkg::link_cfg_t core_cfg,
  output jesd_up_pkg::link_cfg_t device_cfg
);

  logic                    wreq;
  jesd_up_pkg::addr_t      waddr;
  jesd_up_pkg::addr_t      raddr;
  jesd_up_pkg::data_t      wdata;
  jesd_up_pkg::data_t      rdata;
  logic                    link_reset;
  jesd_up_pkg::link_cfg_t  cfg;
  logic                    core_ready;
  logic                    device_ready;
  jesd_up_pkg::clk_count_t core_count;
  jesd_up_pkg::clk_count_t device_count;

  jesd_up_bus_bridge bus_bridge_i (
    .up_clk (up_clk), .core_reset_all (core_reset_all),
    .req (req), .req_valid (req_valid), .req_ready (req_ready),
    .rsp (rsp), .rsp_valid (rsp_valid), .rsp_ready (rsp_ready),
    .wreq (wreq), .waddr (waddr), .raddr (raddr), .wdata (wdata), .rdata (rdata)
  );

  jesd_up_regmap regmap_i (
    .up_clk (up_clk), .core_reset_all (core_reset_all),
    .wreq (wreq), .waddr (waddr), .raddr (raddr), .wdata (wdata), .rdata (rdata),
    .irq_trigger (irq_trigger), .irq (irq),
    .link_reset (link_reset), .cfg (cfg),
    .core_ready (core_ready), .device_ready (device_ready),
    .core_count (core_count), .device_count (device_count)
  );

  jesd_up_domain_ctrl core_ctrl (
    .up_clk (up_clk), .core_reset_all (core_reset_all), .d_clk (core_clk),
    .link_reset (link_reset), .ext_reset (core_reset_ext), .cfg (cfg),
    .d_reset (core_reset), .d_cfg (core_cfg),
    .ready (core_ready), .clk_count (core_count)
  );

  // the device domain has no external reset source.
  jesd_up_domain_ctrl device_ctrl (
    .up_clk (up_clk), .core_reset_all (core_reset_all), .d_clk (device_clk),
    .link_reset (link_reset), .ext_reset (1'b0), .cfg (cfg),
    .d_reset (device_reset), .d_cfg (device_cfg),
    .ready (device_ready), .clk_count (device_count)
  );

endmodule

//--- jesd_up_properties.sv
// **************************************************************************
// Bound assertions for the bus bridge and the register map.
// **************************************************************************

`timescale 1ns/1ps

module jesd_up_properties (
  input logic                   up_clk,
  input logic                   core_reset_all,
  input jesd_up_pkg::bus_rsp_t  rsp,
  input logic                   rsp_valid,
  input logic                   rsp_ready,
  input logic                   link_reset,
  input jesd_up_pkg::link_cfg_t cfg
);

  // a stalled response keeps its valid and its data.
  rsp_held: assert property (@(posedge up_clk) disable iff (core_reset_all)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("response changed while stalled");

  // config is frozen while the link runs.
  cfg_locked: assert property (@(posedge up_clk) disable iff (core_reset_all)
    !link_reset |=> $stable(cfg))
    else $error("link configuration changed with link_reset low");

  reset_values: assert property (@(posedge up_clk)
    core_reset_all |=> !rsp_valid && link_reset)
    else $error("wrong state after reset");

endmodule

// each target ties off the side it does not own.
bind jesd_up_bus_bridge jesd_up_properties bus_props_i (
  .up_clk (up_clk), .core_reset_all (core_reset_all),
  .rsp (rsp), .rsp_valid (rsp_valid), .rsp_ready (rsp_ready),
  .link_reset (1'b1), .cfg ('0)
);

bind jesd_up_regmap jesd_up_properties regmap_props_i (
  .up_clk (up_clk), .core_reset_all (core_reset_all),
  .rsp ('0), .rsp_valid (1'b0), .rsp_ready (1'b1),
  .link_reset (link_reset), .cfg (cfg)
);

//--- jesd_up_tb.sv
// **************************************************************************
// Testbench for the JESD204 processor-side control. Random register traffic
// against a shadow-register model, with stalls on the response side.
// **************************************************************************

`timescale 1ns/1ps

`include "jesd_up_params.svh"

module jesd_up_tb;

  localparam logic [31:0] SEED = 32'h855f_81b1;
  localparam int ROUNDS = 24;
  localparam int WIN = `JESD_UP_CLKMON_WINDOW;
  localparam int UP_PERIOD = 8;
  localparam int CORE_PERIOD = 6;
  localparam int DEVICE_PERIOD = 10;
  localparam int TXN_BUDGET = 20 * ROUNDS + 200; // upper bound on bus transactions.
  localparam int TIMEOUT_NS = (TXN_BUDGET * 40 + 4 * WIN) * UP_PERIOD;
  localparam logic [9:0] OPMF_ONES = 10'((1 << `JESD_UP_DPW_LOG2) - 1);

  logic                   up_clk;
  logic                   core_clk;
  logic                   device_clk;
  logic                   core_reset_all;
  logic                   core_reset_ext;
  jesd_up_pkg::bus_req_t  req;
  logic                   req_valid;
  logic                   req_ready;
  jesd_up_pkg::bus_rsp_t  rsp;
  logic                   rsp_valid;
  logic                   rsp_ready;
  jesd_up_pkg::irq_vec_t  irq_trigger;
  logic                   irq;
  logic                   core_reset;
  logic                   device_reset;
  jesd_up_pkg::link_cfg_t core_cfg;
  jesd_up_pkg::link_cfg_t device_cfg;

  // shadow registers.
  jesd_up_pkg::data_t     scratch_m;
  jesd_up_pkg::irq_vec_t  enable_m;
  jesd_up_pkg::irq_vec_t  source_m;
  logic                   link_reset_m;
  jesd_up_pkg::link_cfg_t cfg_m;
  jesd_up_pkg::stat_cnt_t link_enables_m;
  jesd_up_pkg::stat_cnt_t irq_events_m [`JESD_UP_NUM_IRQS];
  int                     checks;
  int                     errors;
  jesd_up_pkg::data_t     rd;

  always #(UP_PERIOD / 2) up_clk = ~up_clk;
  always #(CORE_PERIOD / 2) core_clk = ~core_clk;
  always #(DEVICE_PERIOD / 2) device_clk = ~device_clk;

  jesd_up_top jesd_up_top_i (
    .up_clk (up_clk), .core_reset_all (core_reset_all),
    .core_clk (core_clk), .device_clk (device_clk), .core_reset_ext (core_reset_ext),
    .req (req), .req_valid (req_valid), .req_ready (req_ready),
    .rsp (rsp), .rsp_valid (rsp_valid), .rsp_ready (rsp_ready),
    .irq_trigger (irq_trigger), .irq (irq),
    .core_reset (core_reset), .device_reset (device_reset),
    .core_cfg (core_cfg), .device_cfg (device_cfg)
  );

  // **************************************************************************
  // reference model
  // **************************************************************************

  function automatic void model_write(input jesd_up_pkg::addr_t addr,
                                      input jesd_up_pkg::data_t data);
    if (link_reset_m) begin // config only while the link is held.
      case (addr)
        12'h080: cfg_m.lanes_disable = jesd_up_pkg::lanes_t'(data);
        12'h084: begin
          cfg_m.octets_per_frame = data[23:16];
          cfg_m.octets_per_multiframe = data[9:0] | OPMF_ONES;
        end
        12'h085: begin
          cfg_m.header_mode = data[3:2];
          cfg_m.disable_char_replacement = data[1];
          cfg_m.disable_scrambler = data[0];
        end
        12'h087: cfg_m.beats_per_multiframe = data[7:0];
        default: ;
      endcase
    end
    case (addr)
      12'h002: scratch_m = data;
      12'h020: enable_m = jesd_up_pkg::irq_vec_t'(data);
      12'h021: source_m = source_m & ~jesd_up_pkg::irq_vec_t'(data); // write 1 to clear.
      12'h030: begin
        if (link_reset_m && !data[0]) link_enables_m = link_enables_m + 16'd1;
        link_reset_m = data[0];
      end
      12'h0b0: begin
        if (data[0]) begin
          link_enables_m = '0;
          foreach (irq_events_m[i]) irq_events_m[i] = '0;
        end
      end
      default: ;
    endcase
  endfunction

  function automatic jesd_up_pkg::data_t model_read(input jesd_up_pkg::addr_t addr);
    case (addr)
      12'h000: return `JESD_UP_VERSION;
      12'h002: return scratch_m;
      12'h020: return jesd_up_pkg::data_t'(enable_m);
      12'h021: return jesd_up_pkg::data_t'(source_m & enable_m);
      12'h022: return jesd_up_pkg::data_t'(source_m);
      12'h030: return jesd_up_pkg::data_t'(link_reset_m);
      12'h080: return jesd_up_pkg::data_t'(cfg_m.lanes_disable);
      12'h084: return {8'd0, cfg_m.octets_per_frame, 6'd0, cfg_m.octets_per_multiframe};
      12'h085: begin
        return {28'd0, cfg_m.header_mode, cfg_m.disable_char_replacement,
                cfg_m.disable_scrambler};
      end
      12'h087: return jesd_up_pkg::data_t'(cfg_m.beats_per_multiframe);
      12'h0b1: return jesd_up_pkg::data_t'(link_enables_m);
      12'h0b4: return {irq_events_m[1], irq_events_m[0]};
      default: return '0;
    endcase
  endfunction

  // **************************************************************************
  // checks and bus access
  // **************************************************************************

  function automatic void check_eq(input string what, input jesd_up_pkg::data_t got,
                                   input jesd_up_pkg::data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endfunction

  function automatic void check_cfg(input string what, input jesd_up_pkg::link_cfg_t got);
    checks++;
    assert (got === cfg_m) else begin
      errors++;
      $display("ERROR %0t: %s is 0x%09h, expected 0x%09h", $time, what, got, cfg_m);
    end
  endfunction

  function automatic void check_near(input string what, input int got, input int exp);
    checks++;
    assert (got >= exp - 2 && got <= exp + 2) else begin
      errors++;
      $display("ERROR %0t: %s is %0d, expected %0d +/- 2", $time, what, got, exp);
    end
  endfunction

  task automatic bus_access(input logic is_wr, input jesd_up_pkg::addr_t addr,
                            input jesd_up_pkg::data_t data,
                            output jesd_up_pkg::data_t got);
    jesd_up_pkg::bus_rsp_t held;
    int                    stall;
    @(posedge up_clk);
    req <= '{is_wr, addr, data};
    req_valid <= 1'b1;
    @(negedge up_clk);
    while (!req_ready) @(negedge up_clk);
    @(posedge up_clk); // accepted here.
    req_valid <= 1'b0;
    if (is_wr) model_write(addr, data);
    @(negedge up_clk);
    check_eq("rsp_valid one cycle after accept", jesd_up_pkg::data_t'(rsp_valid), 1);
    check_eq("rsp write flag", jesd_up_pkg::data_t'(rsp.is_write), jesd_up_pkg::data_t'(is_wr));
    held = rsp;
    stall = $urandom_range(3, 0);
    repeat (stall) begin
      @(negedge up_clk);
      check_eq("stalled rsp_valid", jesd_up_pkg::data_t'(rsp_valid), 1);
      check_eq("stalled rsp data", rsp.rdata, held.rdata);
    end
    @(posedge up_clk);
    rsp_ready <= 1'b1;
    @(posedge up_clk); // taken here.
    rsp_ready <= 1'b0;
    got = held.rdata;
  endtask

  task automatic do_write(input jesd_up_pkg::addr_t addr, input jesd_up_pkg::data_t data);
    jesd_up_pkg::data_t unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic read_check(input jesd_up_pkg::addr_t addr);
    jesd_up_pkg::data_t got;
    bus_access(1'b0, addr, '0, got);
    check_eq($sformatf("read 0x%03h", addr), got, model_read(addr));
  endtask

  task automatic check_irq();
    @(negedge up_clk);
    check_eq("irq", jesd_up_pkg::data_t'(irq), jesd_up_pkg::data_t'(|(source_m & enable_m)));
  endtask

  task automatic pulse_trigger(input jesd_up_pkg::irq_vec_t trig);
    @(posedge up_clk);
    irq_trigger <= trig;
    @(posedge up_clk); // source picks it up here.
    irq_trigger <= '0;
    source_m = source_m | trig;
    for (int i = 0; i < `JESD_UP_NUM_IRQS; i++) begin
      if (trig[i]) irq_events_m[i] = irq_events_m[i] + 16'd1;
    end
    @(posedge up_clk);
    check_irq();
  endtask

  task automatic wait_release();
    int n;
    n = 0;
    @(negedge up_clk);
    while ((core_reset || device_reset) && n < 200) begin
      @(negedge up_clk);
      n++;
    end
    checks++;
    assert (!core_reset && !device_reset) else begin
      errors++;
      $display("domain reset did not release within 200 cycles at %0t", $time);
    end
  endtask

  task automatic poll_status(input jesd_up_pkg::data_t exp);
    jesd_up_pkg::data_t got;
    int                 n;
    n = 0;
    bus_access(1'b0, 12'h031, '0, got);
    while (got !== exp && n < 20) begin
      bus_access(1'b0, 12'h031, '0, got);
      n++;
    end
    check_eq("link status 0x031", got, exp);
  endtask

  task automatic random_cfg_writes();
    jesd_up_pkg::addr_t addr;
    repeat (ROUNDS) begin
      addr = 12'h080 | jesd_up_pkg::addr_t'($urandom_range(7, 0));
      do_write(addr, $urandom);
      read_check(addr);
    end
  endtask

  // **************************************************************************
  // stimulus
  // **************************************************************************

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    up_clk = 1'b0;
    core_clk = 1'b0;
    device_clk = 1'b0;
    core_reset_all = 1'b1;
    core_reset_ext = 1'b0;
    req = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b0;
    irq_trigger = '0;
    scratch_m = '0;
    enable_m = '0;
    source_m = '0;
    link_reset_m = 1'b1;
    cfg_m = '0;
    cfg_m.octets_per_multiframe = OPMF_ONES;
    link_enables_m = '0;
    foreach (irq_events_m[i]) irq_events_m[i] = '0;
    checks = 0;
    errors = 0;
    repeat (8) @(posedge up_clk);
    core_reset_all <= 1'b0;
    @(negedge up_clk);
    check_eq("req_ready after reset", jesd_up_pkg::data_t'(req_ready), 1);
    check_eq("irq after reset", jesd_up_pkg::data_t'(irq), 0);
    check_eq("core_reset after reset", jesd_up_pkg::data_t'(core_reset), 1);
    check_eq("device_reset after reset", jesd_up_pkg::data_t'(device_reset), 1);

    // identity, scratch and unmapped space.
    read_check(12'h000);
    repeat (ROUNDS) begin
      do_write(12'h002, $urandom);
      read_check(12'h002);
      read_check(jesd_up_pkg::addr_t'($urandom_range(4095, 256)));
    end

    // config is open while the link is held, then frozen once it runs.
    read_check(12'h084);
    random_cfg_writes();
    do_write(12'h030, 32'd0);
    wait_release();
    check_cfg("core_cfg", core_cfg);
    check_cfg("device_cfg", device_cfg);
    poll_status(32'd3);
    random_cfg_writes();
    check_cfg("core_cfg after locked writes", core_cfg);

    // external core reset drops only the core ready flag.
    @(posedge up_clk);
    core_reset_ext <= 1'b1;
    @(negedge up_clk);
    check_eq("core_reset under ext reset", jesd_up_pkg::data_t'(core_reset), 1);
    poll_status(32'd2);
    @(posedge up_clk);
    core_reset_ext <= 1'b0;
    wait_release();
    poll_status(32'd3);
    check_cfg("core_cfg after ext reset", core_cfg);

    // interrupts.
    repeat (ROUNDS) begin
      case ($urandom_range(2, 0))
        0: do_write(12'h020, $urandom);
        1: pulse_trigger(jesd_up_pkg::irq_vec_t'($urandom_range(3, 1)));
        default: do_write(12'h021, $urandom);
      endcase
      check_irq();
      read_check(12'h021);
      read_check(12'h022);
    end

    // statistics.
    repeat ($urandom_range(4, 2)) begin
      do_write(12'h030, 32'd1);
      do_write(12'h030, 32'd0);
    end
    read_check(12'h0b1);
    read_check(12'h0b4);
    do_write(12'h0b0, 32'd1);
    read_check(12'h0b1);
    read_check(12'h0b4);

    // clock monitors, each window is WIN up_clk cycles.
    repeat (3 * WIN) @(posedge up_clk);
    bus_access(1'b0, 12'h032, '0, rd);
    check_near("core clock count", int'(rd), (WIN * UP_PERIOD) / CORE_PERIOD);
    bus_access(1'b0, 12'h033, '0, rd);
    check_near("device clock count", int'(rd), (WIN * UP_PERIOD) / DEVICE_PERIOD);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
jesd_up_pkg.sv
jesd_up_bus_bridge.sv
jesd_up_clock_mon.sv
jesd_up_domain_ctrl.sv
jesd_up_regmap.sv
jesd_up_top.sv
jesd_up_properties.sv
jesd_up_tb.sv

//--- Makefile
# Verilator build and run for the JESD204 processor-side control testbench.

SRCS := $(wildcard jesd_up_*.sv jesd_up_*.svh) vlog.f

.PHONY: all run clean

all: run

obj_dir/Vjesd_up_tb: $(SRCS)
	verilator --binary --timing --assert --top-module jesd_up_tb -f vlog.f

run: obj_dir/Vjesd_up_tb
	./obj_dir/Vjesd_up_tb | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
